// ==== run.sh ====
#!/bin/sh
# build the resource table testbench with Verilator, run it and scan the log
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module tb_resource_table \
  -f sources.f -o tb_resource_table > build.log 2>&1 ||
  { cat build.log; echo "verilator build failed, see build.log"; exit 1; }
./obj_dir/tb_resource_table > sim.log 2>&1 ||
  { cat sim.log; echo "simulator exited with an error"; exit 1; }
cat sim.log
grep -q "Simulation FAILED" sim.log && exit 1
exit 0

// ==== source/free_space_scan.sv ====
// largest free gap search over a list walked in start order
module free_space_scan #(
  parameter int NUM_RES_SLOTS = res_table_pkg::DEF_NUM_RES_SLOTS
) (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      clear_i,
  input  logic                      take_i,
  input  logic                      tail_i,
  input  res_table_pkg::res_addr_t  start_i,
  input  res_table_pkg::res_size_t  size_i,
  output res_table_pkg::res_size_t  best_size_o,
  output res_table_pkg::res_addr_t  best_addr_o
);
  import res_table_pkg::*;

  localparam res_size_t SPACE_END = res_size_t'(NUM_RES_SLOTS);

  res_size_t prev_end_q;  // end of the last entry taken
  res_size_t run_size_q;  // best gap so far in this walk
  res_addr_t run_addr_q;
  res_size_t gap;
  logic      better;

  // the tail gap runs up to the end of the resource space
  assign gap    = tail_i ? (SPACE_END - prev_end_q) : ({1'b0, start_i} - prev_end_q);
  assign better = gap > run_size_q;  // strict compare so the earliest gap wins ties

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      prev_end_q  <= '0;
      run_size_q  <= '0;
      run_addr_q  <= '0;
      best_size_o <= '0;
      best_addr_o <= '0;
    end else if (clear_i) begin
      prev_end_q <= '0;
      run_size_q <= '0;
      run_addr_q <= '0;
    end else if (take_i) begin
      if (better) begin
        run_size_q <= gap;
        run_addr_q <= res_addr_t'(prev_end_q);
      end
      prev_end_q <= {1'b0, start_i} + size_i;
    end else if (tail_i) begin
      // published result only moves here
      best_size_o <= better ? gap : run_size_q;
      best_addr_o <= better ? res_addr_t'(prev_end_q) : run_addr_q;
    end
  end

  a_take_tail: assert property (@(posedge clk) disable iff (!rst_n)
    !(take_i && tail_i))
    else $error("scan take and tail together");

  a_sorted: assert property (@(posedge clk) disable iff (!rst_n)
    take_i |-> {1'b0, start_i} >= prev_end_q)
    else $error("entry starts before the previous end");

endmodule

// ==== source/res_entry_ram.sv ====
// list entry memory with registered read port and whole-entry or single-link writes
module res_entry_ram #(
  parameter int NUM_CU       = res_table_pkg::DEF_NUM_CU,
  parameter int NUM_WG_SLOTS = res_table_pkg::DEF_NUM_WG_SLOTS
) (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      rd_en_i,
  input  res_table_pkg::cu_id_t     cu_i,
  input  res_table_pkg::slot_id_t   addr_i,
  input  logic                      wr_entry_i,
  input  logic                      wr_prev_i,
  input  logic                      wr_next_i,
  input  res_table_pkg::res_addr_t  wr_start_i,
  input  res_table_pkg::res_size_t  wr_size_i,
  input  res_table_pkg::slot_id_t   wr_prev_link_i,
  input  res_table_pkg::slot_id_t   wr_next_link_i,
  output logic                      rd_valid_o,
  output res_table_pkg::res_addr_t  rd_start_o,
  output res_table_pkg::res_size_t  rd_size_o,
  output res_table_pkg::slot_id_t   rd_prev_o,
  output res_table_pkg::slot_id_t   rd_next_o
);
  import res_table_pkg::*;

  localparam int DEPTH = NUM_CU * NUM_WG_SLOTS;
  localparam int IDX_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

  res_addr_t        start_mem [DEPTH];
  res_size_t        size_mem  [DEPTH];
  slot_id_t         prev_mem  [DEPTH];
  slot_id_t         next_mem  [DEPTH];
  logic [IDX_W-1:0] idx;

  assign idx = IDX_W'(int'(cu_i) * NUM_WG_SLOTS + int'(addr_i));  // unit major

  always_ff @(posedge clk) begin
    if (wr_entry_i) begin
      start_mem[idx] <= wr_start_i;
      size_mem[idx]  <= wr_size_i;
    end
    if (wr_entry_i || wr_prev_i) prev_mem[idx] <= wr_prev_link_i;
    if (wr_entry_i || wr_next_i) next_mem[idx] <= wr_next_link_i;
    if (rd_en_i) begin
      rd_start_o <= start_mem[idx];
      rd_size_o  <= size_mem[idx];
      rd_prev_o  <= prev_mem[idx];
      rd_next_o  <= next_mem[idx];
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) rd_valid_o <= 1'b0;
    else        rd_valid_o <= rd_en_i;
  end

  a_no_rd_wr: assert property (@(posedge clk) disable iff (!rst_n)
    !(rd_en_i && (wr_entry_i || wr_prev_i || wr_next_i)))
    else $error("entry read and write in the same cycle");

  a_addr_range: assert property (@(posedge clk) disable iff (!rst_n)
    (rd_en_i || wr_entry_i || wr_prev_i || wr_next_i) |-> int'(addr_i) < NUM_WG_SLOTS)
    else $error("entry access beyond the slot range");

endmodule

// ==== source/res_head_store.sv ====
// per compute unit list head pointers with a combinational read port
module res_head_store #(
  parameter int NUM_CU = res_table_pkg::DEF_NUM_CU
) (
  input  logic                     clk,
  input  logic                     rst_n,
  input  res_table_pkg::cu_id_t    cu_i,
  input  logic                     wr_i,
  input  res_table_pkg::slot_id_t  head_i,
  output res_table_pkg::slot_id_t  head_o
);
  import res_table_pkg::*;

  slot_id_t heads_q [NUM_CU];

  assign head_o = heads_q[cu_i];

  // an END head means the unit has no entries yet
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < NUM_CU; i++) begin
        heads_q[i] <= SLOT_END;
      end
    end else if (wr_i) begin
      heads_q[cu_i] <= head_i;
    end
  end

endmodule

// ==== source/res_table_ctrl.sv ====
// controller FSM sequencing list insertion, removal and the free space walk
module res_table_ctrl (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      alloc_en_i,
  input  logic                      dealloc_en_i,
  input  res_table_pkg::cu_id_t     alloc_cu_i,
  input  res_table_pkg::cu_id_t     dealloc_cu_i,
  input  res_table_pkg::slot_id_t   alloc_slot_i,
  input  res_table_pkg::slot_id_t   dealloc_slot_i,
  input  res_table_pkg::res_size_t  alloc_size_i,
  input  res_table_pkg::res_addr_t  alloc_start_i,
  input  res_table_pkg::slot_id_t   head_i,
  input  logic                      rd_valid_i,
  input  res_table_pkg::res_addr_t  rd_start_i,
  input  res_table_pkg::res_size_t  rd_size_i,
  input  res_table_pkg::slot_id_t   rd_prev_i,
  input  res_table_pkg::slot_id_t   rd_next_i,
  output logic                      done_o,
  output res_table_pkg::cu_id_t     cu_o,
  output logic                      head_wr_o,
  output res_table_pkg::slot_id_t   head_o,
  output logic                      rd_en_o,
  output res_table_pkg::slot_id_t   addr_o,
  output logic                      wr_entry_o,
  output logic                      wr_prev_o,
  output logic                      wr_next_o,
  output res_table_pkg::res_addr_t  wr_start_o,
  output res_table_pkg::res_size_t  wr_size_o,
  output res_table_pkg::slot_id_t   wr_prev_link_o,
  output res_table_pkg::slot_id_t   wr_next_link_o,
  output logic                      scan_clear_o,
  output logic                      scan_take_o,
  output logic                      scan_tail_o
);
  import res_table_pkg::*;

  ctrl_state_e state_q;
  logic        alloc_q;  // request kind
  cu_id_t      cu_q;
  slot_id_t    slot_q;
  res_size_t   size_q;
  res_addr_t   start_q;
  slot_id_t    head_q;   // working copy of the unit head
  slot_id_t    cur_q;    // slot of the entry on the read port
  slot_id_t    prev_q;
  slot_id_t    next_q;
  logic        walk_more;

  // keep searching while the entry starts at or below the new one and is not the tail
  assign walk_more = rd_valid_i && (rd_start_i <= start_q) && (rd_next_i != SLOT_END);

  // head store is read combinationally in the request cycle
  assign cu_o       = (state_q == ST_IDLE) ? (alloc_en_i ? alloc_cu_i : dealloc_cu_i) : cu_q;
  assign head_o     = head_q;
  assign wr_start_o = start_q;
  assign wr_size_o  = size_q;

  always_comb begin
    rd_en_o        = 1'b0;
    addr_o         = slot_q;
    wr_entry_o     = 1'b0;
    wr_prev_o      = 1'b0;
    wr_next_o      = 1'b0;
    wr_prev_link_o = prev_q;
    wr_next_link_o = next_q;
    scan_clear_o   = 1'b0;
    scan_take_o    = 1'b0;
    scan_tail_o    = 1'b0;
    head_wr_o      = 1'b0;
    done_o         = 1'b0;
    case (state_q)
      ST_A_FIRST: begin
        rd_en_o = 1'b1;
        addr_o  = head_q;
      end
      ST_A_WALK: begin
        if (walk_more) begin
          rd_en_o = 1'b1;
          addr_o  = rd_next_i;
        end
      end
      ST_A_NEW:  wr_entry_o = 1'b1;  // whole entry at the new slot
      ST_D_READ: rd_en_o = 1'b1;
      ST_LINK_PREV: begin
        addr_o         = prev_q;
        wr_next_o      = (prev_q != SLOT_HEAD);
        wr_next_link_o = alloc_q ? slot_q : next_q;
      end
      ST_LINK_NEXT: begin
        addr_o         = next_q;
        wr_prev_o      = (next_q != SLOT_END);
        wr_prev_link_o = alloc_q ? slot_q : prev_q;
      end
      ST_S_CLEAR: begin
        scan_clear_o = 1'b1;
        rd_en_o      = (head_q != SLOT_END);
        addr_o       = head_q;
      end
      ST_S_WALK: begin
        scan_take_o = rd_valid_i;
        if (rd_valid_i && rd_next_i != SLOT_END) begin
          rd_en_o = 1'b1;
          addr_o  = rd_next_i;
        end
      end
      ST_S_TAIL: begin
        scan_tail_o = 1'b1;
        head_wr_o   = 1'b1;
      end
      ST_DONE: done_o = 1'b1;
      default: ;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= ST_IDLE;
      alloc_q <= 1'b0;
    end else begin
      case (state_q)
        ST_IDLE: begin
          if (alloc_en_i) begin
            alloc_q <= 1'b1;
            state_q <= (head_i == SLOT_END) ? ST_A_NEW : ST_A_FIRST;
          end else if (dealloc_en_i) begin
            alloc_q <= 1'b0;
            state_q <= ST_D_READ;
          end
        end
        ST_A_FIRST: state_q <= ST_A_WALK;
        ST_A_WALK:  if (rd_valid_i && !walk_more) state_q <= ST_A_NEW;
        ST_A_NEW:   state_q <= ST_LINK_PREV;
        ST_D_READ:  state_q <= ST_D_CHECK;
        ST_D_CHECK: if (rd_valid_i) state_q <= ST_LINK_PREV;
        ST_LINK_PREV: state_q <= ST_LINK_NEXT;
        ST_LINK_NEXT: state_q <= ST_S_CLEAR;
        ST_S_CLEAR: state_q <= (head_q == SLOT_END) ? ST_S_TAIL : ST_S_WALK;
        ST_S_WALK:  if (rd_valid_i && rd_next_i == SLOT_END) state_q <= ST_S_TAIL;
        ST_S_TAIL:  state_q <= ST_DONE;
        default:    state_q <= ST_IDLE;  // done and unused codes
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (rd_en_o) cur_q <= addr_o;
    case (state_q)
      ST_IDLE: begin
        if (alloc_en_i) begin
          cu_q    <= alloc_cu_i;
          slot_q  <= alloc_slot_i;
          size_q  <= alloc_size_i;
          start_q <= alloc_start_i;
          head_q  <= head_i;
          prev_q  <= SLOT_HEAD;  // empty list case
          next_q  <= SLOT_END;
        end else if (dealloc_en_i) begin
          cu_q   <= dealloc_cu_i;
          slot_q <= dealloc_slot_i;
          head_q <= head_i;
        end
      end
      ST_A_WALK: begin
        if (rd_valid_i && rd_start_i > start_q) begin
          prev_q <= rd_prev_i;
          next_q <= cur_q;
        end else if (rd_valid_i && rd_next_i == SLOT_END) begin
          prev_q <= cur_q;   // new tail
          next_q <= SLOT_END;
        end
      end
      ST_D_CHECK: begin
        if (rd_valid_i) begin
          prev_q <= rd_prev_i;
          next_q <= rd_next_i;
        end
      end
      ST_LINK_PREV: if (prev_q == SLOT_HEAD) head_q <= alloc_q ? slot_q : next_q;
      default: ;
    endcase
  end

  a_en_excl: assert property (@(posedge clk) disable iff (!rst_n)
    !(alloc_en_i && dealloc_en_i))
    else $error("alloc and dealloc requested together");

  a_en_idle: assert property (@(posedge clk) disable iff (!rst_n)
    (alloc_en_i || dealloc_en_i) |-> state_q == ST_IDLE)
    else $error("request while the table is busy");

endmodule

// ==== source/res_table_pkg.sv ====
// widths, vector types, list markers, default sizes and controller states of the resource table
package res_table_pkg;

  localparam int RES_ID_W  = 6;  // resource address bits
  localparam int SLOT_ID_W = 4;  // slot number plus one bit for the markers
  localparam int CU_ID_W   = 1;

  typedef logic [RES_ID_W-1:0] res_addr_t;
  typedef logic [RES_ID_W:0]   res_size_t;  // one more bit so a whole empty space fits
  typedef logic [SLOT_ID_W-1:0] slot_id_t;
  typedef logic [CU_ID_W-1:0]  cu_id_t;

  localparam slot_id_t SLOT_END  = '1;  // no next entry, or empty list
  localparam slot_id_t SLOT_HEAD = SLOT_END - slot_id_t'(1);  // no previous entry

  localparam int DEF_NUM_CU        = 2;
  localparam int DEF_NUM_WG_SLOTS  = 8;
  localparam int DEF_NUM_RES_SLOTS = 64;

  typedef enum logic [3:0] {
    ST_IDLE,
    ST_A_FIRST,    // read the list head
    ST_A_WALK,     // search the insertion point
    ST_A_NEW,
    ST_D_READ,
    ST_D_CHECK,
    ST_LINK_PREV,  // patch predecessor next link or head copy
    ST_LINK_NEXT,  // patch successor prev link
    ST_S_CLEAR,
    ST_S_WALK,
    ST_S_TAIL,
    ST_DONE
  } ctrl_state_e;

endpackage

// ==== source/resource_table.sv ====
// resource table top level connecting controller, entry memory, head store and gap scanner
module resource_table #(
  parameter int NUM_CU        = res_table_pkg::DEF_NUM_CU,
  parameter int NUM_WG_SLOTS  = res_table_pkg::DEF_NUM_WG_SLOTS,
  parameter int NUM_RES_SLOTS = res_table_pkg::DEF_NUM_RES_SLOTS
) (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      alloc_en_i,
  input  logic                      dealloc_en_i,
  input  res_table_pkg::cu_id_t     alloc_cu_i,
  input  res_table_pkg::cu_id_t     dealloc_cu_i,
  input  res_table_pkg::slot_id_t   alloc_slot_i,
  input  res_table_pkg::slot_id_t   dealloc_slot_i,
  input  res_table_pkg::res_size_t  alloc_size_i,
  input  res_table_pkg::res_addr_t  alloc_start_i,
  output logic                      done_o,
  output res_table_pkg::res_size_t  biggest_size_o,
  output res_table_pkg::res_addr_t  biggest_addr_o
);
  import res_table_pkg::*;

  cu_id_t    cu;
  logic      head_wr;
  slot_id_t  head_wdata;
  slot_id_t  head_rdata;
  logic      rd_en;
  slot_id_t  addr;
  logic      wr_entry;
  logic      wr_prev;
  logic      wr_next;
  res_addr_t wr_start;
  res_size_t wr_size;
  slot_id_t  wr_prev_link;
  slot_id_t  wr_next_link;
  logic      rd_valid;
  res_addr_t rd_start;
  res_size_t rd_size;
  slot_id_t  rd_prev;
  slot_id_t  rd_next;
  logic      scan_clear;
  logic      scan_take;
  logic      scan_tail;

  res_table_ctrl u_ctrl (
    .clk, .rst_n, .alloc_en_i, .dealloc_en_i, .alloc_cu_i, .dealloc_cu_i,
    .alloc_slot_i, .dealloc_slot_i, .alloc_size_i, .alloc_start_i,
    .head_i(head_rdata), .rd_valid_i(rd_valid), .rd_start_i(rd_start), .rd_size_i(rd_size),
    .rd_prev_i(rd_prev), .rd_next_i(rd_next),
    .done_o, .cu_o(cu), .head_wr_o(head_wr), .head_o(head_wdata), .rd_en_o(rd_en),
    .addr_o(addr), .wr_entry_o(wr_entry), .wr_prev_o(wr_prev), .wr_next_o(wr_next),
    .wr_start_o(wr_start), .wr_size_o(wr_size), .wr_prev_link_o(wr_prev_link),
    .wr_next_link_o(wr_next_link), .scan_clear_o(scan_clear), .scan_take_o(scan_take),
    .scan_tail_o(scan_tail)
  );

  res_entry_ram #(.NUM_CU(NUM_CU), .NUM_WG_SLOTS(NUM_WG_SLOTS)) u_entry_ram (
    .clk, .rst_n, .rd_en_i(rd_en), .cu_i(cu), .addr_i(addr), .wr_entry_i(wr_entry),
    .wr_prev_i(wr_prev), .wr_next_i(wr_next), .wr_start_i(wr_start), .wr_size_i(wr_size),
    .wr_prev_link_i(wr_prev_link), .wr_next_link_i(wr_next_link),
    .rd_valid_o(rd_valid), .rd_start_o(rd_start), .rd_size_o(rd_size),
    .rd_prev_o(rd_prev), .rd_next_o(rd_next)
  );

  res_head_store #(.NUM_CU(NUM_CU)) u_head_store (
    .clk, .rst_n, .cu_i(cu), .wr_i(head_wr), .head_i(head_wdata), .head_o(head_rdata)
  );

  // scanner reads entry data straight from the memory read port
  free_space_scan #(.NUM_RES_SLOTS(NUM_RES_SLOTS)) u_scan (
    .clk, .rst_n, .clear_i(scan_clear), .take_i(scan_take), .tail_i(scan_tail),
    .start_i(rd_start), .size_i(rd_size),
    .best_size_o(biggest_size_o), .best_addr_o(biggest_addr_o)
  );

endmodule

// ==== sources.f ====
+incdir+include
source/res_table_pkg.sv
source/res_entry_ram.sv
source/res_head_store.sv
source/free_space_scan.sv
source/res_table_ctrl.sv
source/resource_table.sv
verif/tb_resource_table.sv

// ==== include/res_table_model.svh ====
// reference model of the per unit entry lists and the largest gap rule
`ifndef RES_TABLE_MODEL_SVH
`define RES_TABLE_MODEL_SVH

int m_cnt   [NUM_CU];
int m_start [NUM_CU][NUM_WG_SLOTS];  // kept in start order
int m_size  [NUM_CU][NUM_WG_SLOTS];
int m_slot  [NUM_CU][NUM_WG_SLOTS];

// new entry goes in front of the first entry with a greater start
function automatic void model_insert(input int cu, input int slot, input int start,
                                     input int size);
  int pos;
  pos = m_cnt[cu];
  while (pos > 0 && m_start[cu][pos-1] > start) begin
    m_start[cu][pos] = m_start[cu][pos-1];
    m_size[cu][pos]  = m_size[cu][pos-1];
    m_slot[cu][pos]  = m_slot[cu][pos-1];
    pos--;
  end
  m_start[cu][pos] = start;
  m_size[cu][pos]  = size;
  m_slot[cu][pos]  = slot;
  m_cnt[cu]++;
endfunction

function automatic void model_remove(input int cu, input int slot);
  int pos;
  int i;
  pos = 0;
  while (m_slot[cu][pos] != slot) pos++;
  for (i = pos; i < m_cnt[cu] - 1; i++) begin
    m_start[cu][i] = m_start[cu][i+1];
    m_size[cu][i]  = m_size[cu][i+1];
    m_slot[cu][i]  = m_slot[cu][i+1];
  end
  m_cnt[cu]--;
endfunction

function automatic bit model_has_slot(input int cu, input int slot);
  int i;
  for (i = 0; i < m_cnt[cu]; i++) begin
    if (m_slot[cu][i] == slot) return 1'b1;
  end
  return 1'b0;
endfunction

// gap k lies in front of entry k and the gap after the last entry is the tail
function automatic void gap_at(input int cu, input int k, output int g_addr, output int g_len);
  int prev_end;
  int next_start;
  prev_end   = (k == 0) ? 0 : m_start[cu][k-1] + m_size[cu][k-1];
  next_start = (k == m_cnt[cu]) ? NUM_RES_SLOTS : m_start[cu][k];
  g_addr     = prev_end;
  g_len      = next_start - prev_end;
endfunction

function automatic void ref_biggest(input int cu, output int b_size, output int b_addr);
  int g_addr;
  int g_len;
  int k;
  b_size = 0;
  b_addr = 0;
  for (k = 0; k <= m_cnt[cu]; k++) begin
    gap_at(cu, k, g_addr, g_len);
    if (g_len > b_size) begin  // only a strictly larger gap replaces the best
      b_size = g_len;
      b_addr = g_addr;
    end
  end
endfunction

`endif

// ==== verif/tb_resource_table.sv ====
// testbench for the resource table with directed and random list operations
module tb_resource_table;
  import res_table_pkg::*;

  localparam int NUM_CU         = DEF_NUM_CU;
  localparam int NUM_WG_SLOTS   = DEF_NUM_WG_SLOTS;
  localparam int NUM_RES_SLOTS  = DEF_NUM_RES_SLOTS;
  localparam int NUM_RANDOM     = 200;
  localparam int NUM_OPS        = 16 + NUM_RANDOM;  // directed plus random
  localparam int TIMEOUT_CYCLES = NUM_OPS * (2 * NUM_WG_SLOTS + 10) + 100;

  logic      clk;
  logic      rst_n;
  logic      alloc_en;
  logic      dealloc_en;
  cu_id_t    alloc_cu;
  cu_id_t    dealloc_cu;
  slot_id_t  alloc_slot;
  slot_id_t  dealloc_slot;
  res_size_t alloc_size;
  res_addr_t alloc_start;
  logic      done;
  res_size_t biggest_size;
  res_addr_t biggest_addr;

  int        error_count;
  int        check_count;
  int        cycle_count;
  int        exp_cu;
  int        exp_size;
  int        exp_addr;
  string     test_name;
  logic      done_last;
  res_size_t size_last;
  res_addr_t addr_last;

  `include "res_table_model.svh"

  resource_table #(
    .NUM_CU(NUM_CU), .NUM_WG_SLOTS(NUM_WG_SLOTS), .NUM_RES_SLOTS(NUM_RES_SLOTS)
  ) u_resource_table (
    .clk(clk), .rst_n(rst_n), .alloc_en_i(alloc_en), .dealloc_en_i(dealloc_en),
    .alloc_cu_i(alloc_cu), .dealloc_cu_i(dealloc_cu), .alloc_slot_i(alloc_slot),
    .dealloc_slot_i(dealloc_slot), .alloc_size_i(alloc_size), .alloc_start_i(alloc_start),
    .done_o(done), .biggest_size_o(biggest_size), .biggest_addr_o(biggest_addr)
  );

  always #2 clk = ~clk;

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    check_count++;
    if (expected !== actual) begin
      $display("[FAIL] %s: expected %0d, actual %0d", name, expected, actual);
      error_count++;
    end
  endtask

  task automatic wait_for_done();
    @(negedge clk);
    while (!done) @(negedge clk);
  endtask

  task automatic issue_alloc(input string name, input int cu, input int slot,
                             input int start, input int size);
    @(posedge clk);
    #1;
    alloc_en    = 1'b1;
    alloc_cu    = cu_id_t'(cu);
    alloc_slot  = slot_id_t'(slot);
    alloc_start = res_addr_t'(start);
    alloc_size  = res_size_t'(size);
    test_name   = name;
    exp_cu      = cu;
    model_insert(cu, slot, start, size);
    @(posedge clk);
    #1;
    alloc_en = 1'b0;
    wait_for_done();
  endtask

  task automatic issue_dealloc(input string name, input int cu, input int slot);
    @(posedge clk);
    #1;
    dealloc_en   = 1'b1;
    dealloc_cu   = cu_id_t'(cu);
    dealloc_slot = slot_id_t'(slot);
    test_name    = name;
    exp_cu       = cu;
    model_remove(cu, slot);
    @(posedge clk);
    #1;
    dealloc_en = 1'b0;
    wait_for_done();
  endtask

  // legal random request whose new range fits inside a free gap
  task automatic random_op();
    int cu;
    int k;
    int t;
    int g_addr;
    int g_len;
    int slot;
    int size;
    cu    = $urandom_range(NUM_CU - 1);
    g_len = 0;
    k     = $urandom_range(m_cnt[cu]);
    for (t = 0; t <= m_cnt[cu] && g_len == 0; t++) begin
      gap_at(cu, (k + t) % (m_cnt[cu] + 1), g_addr, g_len);
    end
    if (m_cnt[cu] == 0 ||
        (m_cnt[cu] < NUM_WG_SLOTS && g_len > 0 && $urandom_range(1) == 1)) begin
      slot = $urandom_range(NUM_WG_SLOTS - 1);
      while (model_has_slot(cu, slot)) slot = (slot + 1) % NUM_WG_SLOTS;
      size = 1 + $urandom_range(g_len - 1);
      issue_alloc("random alloc", cu, slot, g_addr + $urandom_range(g_len - size), size);
    end else begin
      issue_dealloc("random dealloc", cu, m_slot[cu][$urandom_range(m_cnt[cu] - 1)]);
    end
  endtask

  // each done is scored against the unit of the request
  always @(negedge clk) begin
    if (rst_n && done) begin
      if (done_last) begin
        $display("ERROR: done stayed high for more than one cycle");
        error_count++;
      end
      ref_biggest(exp_cu, exp_size, exp_addr);
      check_value({test_name, " size"}, exp_size, 32'(biggest_size));
      check_value({test_name, " addr"}, exp_addr, 32'(biggest_addr));
    end
    if (rst_n && !done && (biggest_size !== size_last || biggest_addr !== addr_last)) begin
      $display("ERROR: biggest space outputs changed outside the done cycle");
      error_count++;
    end
    done_last = done;
    size_last = biggest_size;
    addr_last = biggest_addr;
  end

  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count > TIMEOUT_CYCLES) begin
      $display("ERROR: timeout, run still busy after %0d cycles", cycle_count);
      $display("Simulation FAILED");
      $finish;
    end
  end

  initial begin
    void'($urandom(32'hd84e8f00));
    clk          = 1'b0;
    rst_n        = 1'b0;
    alloc_en     = 1'b0;
    dealloc_en   = 1'b0;
    alloc_cu     = '0;
    dealloc_cu   = '0;
    alloc_slot   = '0;
    dealloc_slot = '0;
    alloc_size   = '0;
    alloc_start  = '0;
    error_count  = 0;
    check_count  = 0;
    cycle_count  = 0;
    done_last    = 1'b0;
    size_last    = '0;
    addr_last    = '0;
    repeat (5) @(posedge clk);
    #1;
    rst_n = 1'b1;
    check_value("reset done", 0, 32'(done));
    check_value("reset size", 0, 32'(biggest_size));
    check_value("reset addr", 0, 32'(biggest_addr));
    issue_alloc("empty unit tail gap", 0, 0, 10, 5);
    issue_alloc("empty unit leading gap", 1, 0, 40, 20);
    issue_alloc("insert at head", 0, 1, 2, 3);
    issue_alloc("insert at tail", 0, 2, 30, 10);
    issue_alloc("insert in middle", 0, 3, 20, 4);
    issue_alloc("insert after old tail", 0, 4, 46, 6);
    issue_alloc("earliest gap tie", 0, 5, 58, 6);  // three gaps of 6 left
    issue_dealloc("remove first", 0, 1);
    issue_dealloc("remove middle", 0, 3);
    issue_dealloc("remove last", 0, 5);
    issue_dealloc("remove only", 1, 0);
    issue_alloc("interleave cu1 alloc", 1, 2, 0, 32);
    issue_dealloc("interleave cu0 dealloc", 0, 0);
    issue_alloc("interleave cu1 alloc", 1, 5, 40, 8);
    issue_dealloc("interleave cu0 dealloc", 0, 2);
    issue_dealloc("interleave cu0 empty", 0, 4);
    repeat (NUM_RANDOM) random_op();
    repeat (2) @(posedge clk);
    $display("checks: %0d, errors: %0d", check_count, error_count);
    if (error_count == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule
